// File: vlog.f
src/trdb_pkg.sv
src/trdb_isa_pkg.sv
src/trdb_stage_pipe.sv
src/trdb_itype_detector.sv
src/trdb_branch_map.sv
src/trdb_resync_counter.sv
src/trdb_priority.sv
src/trdb_packet_emitter.sv
src/trace_debugger.sv
tests/tb_trace_debugger.sv

// File: run_sim.sh
#!/bin/sh
# builds and runs the trace encoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_trace_debugger -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" sim.log; then
    exit 1
fi
exit 0

// File: tests/tb_trace_debugger.sv
// ####################
// reference model predicts every packet, assertions compare at the next edge
// strobes keep one idle cycle or more so counter and map updates settle
// ####################
`timescale 1ns/10ps

module tb_trace_debugger;

    localparam int unsigned RESYNC_MAX = 4;
    localparam int unsigned CLK_PERIOD = 100;
    // upper bound on retired instructions, sizes the watchdog
    localparam int unsigned NUM_INST   = 80;
    localparam logic [31:0] NOP        = 32'h00000013;
    localparam logic [31:0] BEQ        = 32'h00000063;
    localparam logic [31:0] JALR       = 32'h00008067;
    localparam logic [31:0] ECALL      = 32'h00000073;

    // one strobed instruction with its trap info
    typedef struct packed {
        logic        valid;
        logic        qualified;
        logic [31:0] addr;
        logic [31:0] inst;
        logic [1:0]  priv;
        logic        exc;
        logic        intr;
        logic [4:0]  cause;
    } rec_t;

    typedef struct packed {
        logic [1:0]  ptype;
        logic [3:0]  len;
        logic [79:0] payload;
    } pkt_t;

    logic        clk_i;
    logic        rst_ni;
    logic        inst_valid_i;
    logic        trace_enable_i;
    logic        exception_i;
    logic        interrupt_i;
    logic [4:0]  cause_i;
    logic [1:0]  priv_lvl_i;
    logic [31:0] inst_data_i;
    logic [31:0] pc_i;
    logic        packet_valid_o;
    logic [1:0]  packet_type_o;
    logic [3:0]  packet_length_o;
    logic [79:0] packet_payload_o;

    // model state, mirrors the nc/tc/lc view of the encoder
    rec_t        tc_m;
    rec_t        lc_m;
    logic [30:0] map_m;
    int          cnt_m;
    int          resync_m;
    logic        lc_updis_m;
    pkt_t        exp_q[$];
    pkt_t        exp_pkt;
    logic        check_q;
    logic        stray_q;
    int          errors;
    int          checked;
    integer      seed;
    logic [31:0] pc;
    logic [1:0]  priv;
    logic        enable;

    trace_debugger #(
        .RESYNC_MAX(RESYNC_MAX)
    ) dut (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .inst_valid_i    (inst_valid_i),
        .trace_enable_i  (trace_enable_i),
        .exception_i     (exception_i),
        .interrupt_i     (interrupt_i),
        .cause_i         (cause_i),
        .priv_lvl_i      (priv_lvl_i),
        .inst_data_i     (inst_data_i),
        .pc_i            (pc_i),
        .packet_valid_o  (packet_valid_o),
        .packet_type_o   (packet_type_o),
        .packet_length_o (packet_length_o),
        .packet_payload_o(packet_payload_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // jalr, mret and sret leave the target unknown
    function automatic logic is_updiscon(input logic [31:0] inst);
        return (inst[6:0] == 7'h67 && inst[14:12] == 3'd0) ||
               inst == 32'h30200073 || inst == 32'h10200073;
    endfunction

    // subformat 0, priv at bit 2, address at bit 4
    function automatic pkt_t sync_packet(input rec_t t);
        pkt_t p;
        p = '0;
        p.ptype = 2'd3;
        p.len = 4'd5;
        p.payload[3:2] = t.priv;
        p.payload[35:4] = t.addr;
        return p;
    endfunction

    // decision for tc once its successor nc is known
    function automatic void model_step(input rec_t nc);
        pkt_t p;
        logic traced;
        logic emit;
        p = '0;
        traced = tc_m.valid && tc_m.qualified;
        emit = traced;
        if (traced) begin
            if (!lc_m.qualified) begin
                p = sync_packet(tc_m);
            end else if (lc_m.exc) begin
                p.ptype = 2'd3;
                p.len = 4'd10;
                p.payload[1:0] = 2'd1;
                p.payload[3:2] = tc_m.priv;
                p.payload[4] = lc_m.intr;
                p.payload[9:5] = lc_m.cause;
                p.payload[41:10] = lc_m.addr;
                p.payload[73:42] = tc_m.addr;
            end else if (lc_updis_m && cnt_m == 0) begin
                p.ptype = 2'd2;
                p.len = 4'd4;
                p.payload[31:0] = tc_m.addr;
            end else if (lc_updis_m) begin
                p.ptype = 2'd1;
                p.len = 4'd9;
                p.payload[4:0] = cnt_m[4:0];
                p.payload[35:5] = map_m;
                p.payload[67:36] = tc_m.addr;
            end else if (resync_m == RESYNC_MAX) begin
                p = sync_packet(tc_m);
            end else if (cnt_m == 31) begin
                p.ptype = 2'd1;
                p.len = 4'd5;
                p.payload[4:0] = cnt_m[4:0];
                p.payload[35:5] = map_m;
            end else begin
                emit = 1'b0;
            end
        end
        if (emit) begin
            exp_q.push_back(p);
            // address only packets keep the (empty) map
            if (p.ptype != 2'd2) begin
                map_m = '0;
                cnt_m = 0;
            end
            // a sync packet restarts the count and counts itself
            if (p.ptype == 2'd3) begin
                resync_m = 1;
            end else if (resync_m < RESYNC_MAX) begin
                resync_m++;
            end
        end
        // 1 marks not taken
        if (traced && tc_m.inst[6:0] == 7'h63) begin
            map_m[cnt_m] = (nc.addr == tc_m.addr + 32'd4);
            cnt_m++;
        end
        lc_updis_m = traced && is_updiscon(tc_m.inst);
        lc_m = tc_m;
        tc_m = nc;
    endfunction

    // one strobe, then a random idle gap
    task automatic retire(input logic [31:0] addr, input logic [31:0] inst,
                          input logic exc, input logic intr, input logic [4:0] cause);
        rec_t r;
        int gap;
        r = '{valid: 1'b1, qualified: enable, addr: addr, inst: inst, priv: priv,
              exc: exc, intr: intr, cause: cause};
        model_step(r);
        @(posedge clk_i);
        inst_valid_i   <= 1'b1;
        trace_enable_i <= enable;
        pc_i           <= addr;
        inst_data_i    <= inst;
        priv_lvl_i     <= priv;
        exception_i    <= exc;
        interrupt_i    <= intr;
        cause_i        <= cause;
        @(posedge clk_i);
        inst_valid_i <= 1'b0;
        exception_i  <= 1'b0;
        interrupt_i  <= 1'b0;
        gap = 1 + ($unsigned($random(seed)) % 3);
        repeat (gap) @(posedge clk_i);
    endtask

    task automatic nop_step();
        retire(pc, NOP, 1'b0, 1'b0, 5'd0);
        pc = pc + 32'd4;
    endtask

    task automatic jump_to(input logic [31:0] target);
        retire(pc, JALR, 1'b0, 1'b0, 5'd0);
        pc = target;
    endtask

    // interrupts tag a plain instruction, exceptions an ecall
    task automatic trap_to(input logic [31:0] handler, input logic intr, input logic [4:0] cause);
        retire(pc, intr ? NOP : ECALL, 1'b1, intr, cause);
        pc = handler;
        priv = 2'b11;
    endtask

    // outcome picked at random, taken skips ahead
    task automatic branch_run(input int n);
        int rnd;
        for (int i = 0; i < n; i++) begin
            rnd = $random(seed);
            retire(pc, BEQ, 1'b0, 1'b0, 5'd0);
            pc = rnd[0] ? pc + 32'h10 : pc + 32'd4;
        end
    endtask

    // outputs are stable mid cycle
    always @(negedge clk_i) begin
        check_q = 1'b0;
        stray_q = 1'b0;
        if (packet_valid_o) begin
            if (exp_q.size() == 0) begin
                stray_q = 1'b1;
            end else begin
                exp_pkt = exp_q.pop_front();
                check_q = 1'b1;
                checked++;
            end
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni) !stray_q)
        else begin
            errors++;
            $display("packet_valid_o rose at %0t with no packet expected", $time);
        end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     check_q |-> packet_type_o == exp_pkt.ptype)
        else begin
            errors++;
            $display("[ERROR] %0t: packet type %0d, expected %0d",
                     $time, packet_type_o, exp_pkt.ptype);
        end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     check_q |-> packet_length_o == exp_pkt.len)
        else begin
            errors++;
            $display("[ERROR] %0t: packet length %0d, expected %0d",
                     $time, packet_length_o, exp_pkt.len);
        end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     check_q |-> packet_payload_o == exp_pkt.payload)
        else begin
            errors++;
            $display("[ERROR] %0t: payload %h, expected %h",
                     $time, packet_payload_o, exp_pkt.payload);
        end

    initial begin
        #((NUM_INST * 10 + 100) * CLK_PERIOD);
        $display("timeout: %0d packets still outstanding", exp_q.size());
        $display("Test failures found");
        $finish;
    end

    initial begin
        clk_i = 1'b0;
        rst_ni = 1'b0;
        inst_valid_i = 1'b0;
        trace_enable_i = 1'b0;
        exception_i = 1'b0;
        interrupt_i = 1'b0;
        cause_i = '0;
        priv_lvl_i = '0;
        inst_data_i = '0;
        pc_i = '0;
        tc_m = '0;
        lc_m = '0;
        map_m = '0;
        cnt_m = 0;
        resync_m = 0;
        lc_updis_m = 1'b0;
        check_q = 1'b0;
        stray_q = 1'b0;
        errors = 0;
        checked = 0;
        seed = 63043;
        pc = 32'h1000;
        priv = 2'b00;
        enable = 1'b0;
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;
        // tracing off, nothing may come out
        repeat (4) nop_step();
        // first traced instruction starts with sync
        enable = 1'b1;
        repeat (2) nop_step();
        // branches then jalr, map packet at the target
        branch_run(6);
        jump_to(32'h2000);
        repeat (2) nop_step();
        // jalr on an empty map, address only
        nop_step();
        jump_to(32'h3000);
        repeat (2) nop_step();
        // exception, then interrupt
        trap_to(32'h0100, 1'b0, 5'd11);
        repeat (2) nop_step();
        trap_to(32'h0200, 1'b1, 5'd7);
        nop_step();
        // fills the map
        branch_run(31);
        repeat (2) nop_step();
        // two address only packets, then resync is due
        jump_to(32'h4000);
        nop_step();
        jump_to(32'h5000);
        repeat (4) nop_step();
        // off and on again
        enable = 1'b0;
        repeat (3) nop_step();
        enable = 1'b1;
        repeat (3) nop_step();
        while (exp_q.size() != 0) @(posedge clk_i);
        repeat (4) @(posedge clk_i);
        $display("errors: %0d, packets checked: %0d", errors, checked);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: src/trace_debugger.sv
// ####################
// E-trace style instruction encoder, one retired instruction per strobe
// trace_enable_i qualifies each instruction, lc address doubles as epc
// ####################
`timescale 1ns/10ps

module trace_debugger
    import trdb_pkg::*;
#(
    parameter int unsigned RESYNC_MAX = 16
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   inst_valid_i,
    input  logic                   trace_enable_i,
    input  logic                   exception_i,
    input  logic                   interrupt_i,
    input  logic [CAUSE_LEN-1:0]   cause_i,
    input  logic [PRIV_LEN-1:0]    priv_lvl_i,
    input  logic [INST_LEN-1:0]    inst_data_i,
    input  logic [PC_LEN-1:0]      pc_i,
    output logic                   packet_valid_o,
    output logic [PTYPE_LEN-1:0]   packet_type_o,
    output logic [P_LEN-1:0]       packet_length_o,
    output logic [PAYLOAD_LEN-1:0] packet_payload_o
);

    inst_stage_t                 inst_in;
    trap_stage_t                 trap_in;
    inst_stage_t                 nc_inst;
    inst_stage_t                 tc_inst;
    inst_stage_t                 lc_inst;
    trap_stage_t                 lc_trap;
    logic                        tc_branch;
    logic                        tc_branch_taken;
    logic                        tc_updiscon;
    logic [BRANCH_MAP_LEN-1:0]   branch_map;
    logic [BRANCH_COUNT_LEN-1:0] branch_count;
    logic                        map_full;
    logic                        map_empty;
    logic                        map_add;
    logic                        map_flush;
    logic                        resync_due;
    logic                        resync_clear;
    logic                        emit;
    logic                        with_addr;
    trdb_format_e                packet_format;
    trdb_f_sync_subformat_e      packet_subformat;

    // input records, qualified straight from the enable level
    assign inst_in = '{valid:     inst_valid_i,
                       qualified: trace_enable_i,
                       iaddr:     pc_i,
                       inst_data: inst_data_i,
                       priv:      priv_lvl_i};
    assign trap_in = '{exception: exception_i,
                       interrupt: interrupt_i,
                       cause:     cause_i};

    trdb_stage_pipe #(
        .PAYLOAD_T(inst_stage_t)
    ) i_inst_pipe (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .shift_i(inst_valid_i),
        .data_i (inst_in),
        .nc_o   (nc_inst),
        .tc_o   (tc_inst),
        .lc_o   (lc_inst)
    );

    // only the lc trap record is consumed
    trdb_stage_pipe #(
        .PAYLOAD_T(trap_stage_t)
    ) i_trap_pipe (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .shift_i(inst_valid_i),
        .data_i (trap_in),
        .nc_o   (),
        .tc_o   (),
        .lc_o   (lc_trap)
    );

    trdb_itype_detector i_itype_detector (
        .tc_inst_data_i(tc_inst.inst_data),
        .tc_iaddr_i    (tc_inst.iaddr),
        .nc_iaddr_i    (nc_inst.iaddr),
        .branch_o      (tc_branch),
        .branch_taken_o(tc_branch_taken),
        .updiscon_o    (tc_updiscon)
    );

    trdb_branch_map i_branch_map (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .add_i  (map_add),
        .taken_i(tc_branch_taken),
        .flush_i(map_flush),
        .map_o  (branch_map),
        .count_o(branch_count),
        .full_o (map_full),
        .empty_o(map_empty)
    );

    trdb_resync_counter #(
        .RESYNC_MAX(RESYNC_MAX)
    ) i_resync_counter (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .packet_emitted_i(packet_valid_o),
        .clear_i         (resync_clear),
        .resync_due_o    (resync_due)
    );

    trdb_priority i_priority (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .shift_i       (inst_valid_i),
        .tc_inst_i     (tc_inst),
        .lc_inst_i     (lc_inst),
        .lc_trap_i     (lc_trap),
        .tc_branch_i   (tc_branch),
        .tc_updiscon_i (tc_updiscon),
        .map_full_i    (map_full),
        .map_empty_i   (map_empty),
        .resync_due_i  (resync_due),
        .emit_o        (emit),
        .format_o      (packet_format),
        .subformat_o   (packet_subformat),
        .with_addr_o   (with_addr),
        .map_add_o     (map_add),
        .map_flush_o   (map_flush),
        .resync_clear_o(resync_clear)
    );

    trdb_packet_emitter i_packet_emitter (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .emit_i          (emit),
        .with_addr_i     (with_addr),
        .format_i        (packet_format),
        .subformat_i     (packet_subformat),
        .tc_inst_i       (tc_inst),
        .lc_inst_i       (lc_inst),
        .lc_trap_i       (lc_trap),
        .map_i           (branch_map),
        .count_i         (branch_count),
        .packet_valid_o  (packet_valid_o),
        .packet_type_o   (packet_type_o),
        .packet_length_o (packet_length_o),
        .packet_payload_o(packet_payload_o)
    );

endmodule

// File: src/trdb_packet_emitter.sv
// ####################
// packs and registers one packet per emit_i, LSB first, unused bits zero
// packet_valid_o is a one-cycle strobe, no back-pressure
// ####################
`timescale 1ns/10ps

module trdb_packet_emitter
    import trdb_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        emit_i,
    input  logic                        with_addr_i,
    input  trdb_format_e                format_i,
    input  trdb_f_sync_subformat_e      subformat_i,
    input  inst_stage_t                 tc_inst_i,
    input  inst_stage_t                 lc_inst_i,
    input  trap_stage_t                 lc_trap_i,
    input  logic [BRANCH_MAP_LEN-1:0]   map_i,
    input  logic [BRANCH_COUNT_LEN-1:0] count_i,
    output logic                        packet_valid_o,
    output logic [PTYPE_LEN-1:0]        packet_type_o,
    output logic [P_LEN-1:0]            packet_length_o,
    output logic [PAYLOAD_LEN-1:0]      packet_payload_o
);

    logic [PAYLOAD_LEN-1:0] payload_d;
    logic [P_LEN-1:0]       length_d;

    always_comb begin
        payload_d = '0;
        length_d  = '0;
        case (format_i)
            F_SYNC: begin
                if (subformat_i == SF_EXCEPTION) begin
                    // trapping address from lc, handler from tc
                    payload_d = PAYLOAD_LEN'({tc_inst_i.iaddr, lc_inst_i.iaddr,
                                              lc_trap_i.cause, lc_trap_i.interrupt,
                                              tc_inst_i.priv, subformat_i});
                    length_d  = LEN_EXC;
                end else begin
                    payload_d = PAYLOAD_LEN'({tc_inst_i.iaddr, tc_inst_i.priv, subformat_i});
                    length_d  = LEN_SYNC;
                end
            end
            F_ADDR_ONLY: begin
                payload_d = PAYLOAD_LEN'(tc_inst_i.iaddr);
                length_d  = LEN_ADDR;
            end
            F_ADDR_BRANCH: begin
                if (with_addr_i) begin
                    payload_d = PAYLOAD_LEN'({tc_inst_i.iaddr, map_i, count_i});
                    length_d  = LEN_BMAP_ADDR;
                end else begin
                    payload_d = PAYLOAD_LEN'({map_i, count_i});
                    length_d  = LEN_BMAP_FULL;
                end
            end
            default: begin
                payload_d = '0;
                length_d  = '0;
            end
        endcase
    end

    // outputs hold the last packet between strobes
    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            packet_valid_o   <= 1'b0;
            packet_type_o    <= '0;
            packet_length_o  <= '0;
            packet_payload_o <= '0;
        end else begin
            packet_valid_o <= emit_i;
            if (emit_i) begin
                packet_type_o    <= format_i;
                packet_length_o  <= length_d;
                packet_payload_o <= payload_d;
            end
        end
    end

endmodule

// File: src/trdb_priority.sv
// ####################
// packet decision for the tc instruction, one cycle after each shift
// first matching rule wins, only qualified valid tc emits
// ####################
`timescale 1ns/10ps

module trdb_priority
    import trdb_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   shift_i,
    input  inst_stage_t            tc_inst_i,
    input  inst_stage_t            lc_inst_i,
    input  trap_stage_t            lc_trap_i,
    input  logic                   tc_branch_i,
    input  logic                   tc_updiscon_i,
    input  logic                   map_full_i,
    input  logic                   map_empty_i,
    input  logic                   resync_due_i,
    output logic                   emit_o,
    output trdb_format_e           format_o,
    output trdb_f_sync_subformat_e subformat_o,
    output logic                   with_addr_o,
    output logic                   map_add_o,
    output logic                   map_flush_o,
    output logic                   resync_clear_o
);

    logic decide_q;
    logic lc_updiscon_q;
    logic tc_traced;

    // tc just got its nc successor
    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            decide_q      <= 1'b0;
            lc_updiscon_q <= 1'b0;
        end else begin
            decide_q <= shift_i;
            // follows tc into lc
            if (decide_q) begin
                lc_updiscon_q <= tc_updiscon_i && tc_traced;
            end
        end
    end

    assign tc_traced = tc_inst_i.valid && tc_inst_i.qualified;

    always_comb begin
        emit_o      = 1'b0;
        format_o    = F_SYNC;
        subformat_o = SF_START;
        with_addr_o = 1'b0;
        if (decide_q && tc_traced) begin
            emit_o = 1'b1;
            if (!lc_inst_i.qualified) begin
                // first traced instruction, start sync
                subformat_o = SF_START;
            end else if (lc_trap_i.exception) begin
                // tc is the handler entry
                subformat_o = SF_EXCEPTION;
            end else if (lc_updiscon_q && map_empty_i) begin
                format_o = F_ADDR_ONLY;
            end else if (lc_updiscon_q) begin
                format_o    = F_ADDR_BRANCH;
                with_addr_o = 1'b1;
            end else if (resync_due_i) begin
                subformat_o = SF_START;
            end else if (map_full_i) begin
                // map drained, no address
                format_o = F_ADDR_BRANCH;
            end else begin
                emit_o = 1'b0;
            end
        end
    end

    // tc outcome goes in after any flush
    assign map_add_o      = decide_q && tc_traced && tc_branch_i;
    // format 2 only fires on an empty map
    assign map_flush_o    = emit_o && (format_o != F_ADDR_ONLY);
    assign resync_clear_o = emit_o && (format_o == F_SYNC);

endmodule

// File: src/trdb_resync_counter.sv
// ####################
// counts emitted packets up to RESYNC_MAX, clear wins over increment
// ####################
`timescale 1ns/10ps

module trdb_resync_counter #(
    parameter int unsigned RESYNC_MAX = 16
) (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic packet_emitted_i,
    input  logic clear_i,
    output logic resync_due_o
);

    localparam int unsigned CNT_LEN = $clog2(RESYNC_MAX + 1);

    logic [CNT_LEN-1:0] count_q;

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else if (clear_i) begin
            count_q <= '0;
        end else if (packet_emitted_i && !resync_due_o) begin
            // saturates once due
            count_q <= count_q + 1'b1;
        end
    end

    assign resync_due_o = (count_q == CNT_LEN'(RESYNC_MAX));

endmodule

// File: src/trdb_branch_map.sv
// ####################
// branch outcome map, 1 means not taken
// caller must flush before adding to a full map
// ####################
`timescale 1ns/10ps

module trdb_branch_map
    import trdb_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        add_i,
    input  logic                        taken_i,
    input  logic                        flush_i,
    output logic [BRANCH_MAP_LEN-1:0]   map_o,
    output logic [BRANCH_COUNT_LEN-1:0] count_o,
    output logic                        full_o,
    output logic                        empty_o
);

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            map_o   <= '0;
            count_o <= '0;
        end else if (flush_i) begin
            // new outcome lands in bit 0 of the empty map
            map_o   <= BRANCH_MAP_LEN'(add_i && !taken_i);
            count_o <= BRANCH_COUNT_LEN'(add_i);
        end else if (add_i) begin
            map_o[count_o] <= !taken_i;
            count_o        <= count_o + 1'b1;
        end
    end

    assign full_o  = (count_o == BRANCH_COUNT_LEN'(BRANCH_MAP_LEN));
    assign empty_o = (count_o == '0);

endmodule

// File: src/trdb_itype_detector.sv
// ####################
// classifies the tc instruction, RV32 without compressed forms
// taken means the nc address is not the sequential one
// ####################
`timescale 1ns/10ps

module trdb_itype_detector
    import trdb_pkg::*;
    import trdb_isa_pkg::*;
(
    input  logic [INST_LEN-1:0] tc_inst_data_i,
    input  logic [PC_LEN-1:0]   tc_iaddr_i,
    input  logic [PC_LEN-1:0]   nc_iaddr_i,
    output logic                branch_o,
    output logic                branch_taken_o,
    output logic                updiscon_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_jalr;
    logic       is_xret;

    assign opcode = tc_inst_data_i[6:0];
    assign funct3 = tc_inst_data_i[14:12];

    // conditional branches only, jal is inferable
    assign branch_o = (opcode == OPCODE_BRANCH);

    // outcome read back from the following address
    assign branch_taken_o = branch_o && (nc_iaddr_i != tc_iaddr_i + PC_LEN'(4));

    // target comes from a register
    assign is_jalr = (opcode == OPCODE_JALR) && (funct3 == FUNCT3_JALR);

    // trap return, target from xepc
    assign is_xret = (opcode == OPCODE_SYSTEM) &&
                     ((tc_inst_data_i == INST_MRET) || (tc_inst_data_i == INST_SRET));

    assign updiscon_o = is_jalr || is_xret;

endmodule

// File: src/trdb_stage_pipe.sv
// ####################
// nc/tc/lc record pipe, advances only on shift_i
// ####################
`timescale 1ns/10ps

module trdb_stage_pipe #(
    parameter type PAYLOAD_T = logic
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     shift_i,
    input  PAYLOAD_T data_i,
    output PAYLOAD_T nc_o,
    output PAYLOAD_T tc_o,
    output PAYLOAD_T lc_o
);

    // cleared so every stage starts invalid
    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            nc_o <= '0;
            tc_o <= '0;
            lc_o <= '0;
        end else if (shift_i) begin
            // one step per retired instruction
            nc_o <= data_i;
            tc_o <= nc_o;
            lc_o <= tc_o;
        end
    end

endmodule

// File: src/trdb_isa_pkg.sv
// ####################
// RV32 encodings needed to spot branches and discontinuities
// compressed instructions are not covered
// ####################
package trdb_isa_pkg;

    // major opcodes
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

    // jalr has a single legal funct3
    localparam logic [2:0] FUNCT3_JALR   = 3'b000;

    // trap returns, full words
    localparam logic [31:0] INST_MRET    = 32'h30200073;
    localparam logic [31:0] INST_SRET    = 32'h10200073;

endpackage

// File: src/trdb_pkg.sv
// ####################
// shared widths, packet encodings and stage records of the trace encoder
// payload lengths are whole bytes, rounded up from the packed bit count
// ####################
package trdb_pkg;

    // core interface widths
    localparam int unsigned PC_LEN           = 32;
    localparam int unsigned INST_LEN         = 32;
    localparam int unsigned PRIV_LEN         = 2;
    localparam int unsigned CAUSE_LEN        = 5;

    // branch map sizing, count must reach BRANCH_MAP_LEN
    localparam int unsigned BRANCH_MAP_LEN   = 31;
    localparam int unsigned BRANCH_COUNT_LEN = 5;

    // packet output widths
    localparam int unsigned PAYLOAD_LEN      = 80;
    localparam int unsigned P_LEN            = 4;
    localparam int unsigned PTYPE_LEN        = 2;

    // packet format field
    typedef enum logic [PTYPE_LEN-1:0] {
        F_ADDR_BRANCH = 2'h1,
        F_ADDR_ONLY   = 2'h2,
        F_SYNC        = 2'h3
    } trdb_format_e;

    // subformat of format 3
    typedef enum logic [1:0] {
        SF_START     = 2'h0,
        SF_EXCEPTION = 2'h1
    } trdb_f_sync_subformat_e;

    // one retired instruction as seen by the encoder
    typedef struct packed {
        logic                valid;
        logic                qualified;
        logic [PC_LEN-1:0]   iaddr;
        logic [INST_LEN-1:0] inst_data;
        logic [PRIV_LEN-1:0] priv;
    } inst_stage_t;

    // trap info that travels with its instruction
    typedef struct packed {
        logic                 exception;
        logic                 interrupt;
        logic [CAUSE_LEN-1:0] cause;
    } trap_stage_t;

    // byte lengths per packet kind
    localparam logic [P_LEN-1:0] LEN_SYNC      = 4'd5;
    localparam logic [P_LEN-1:0] LEN_EXC       = 4'd10;
    localparam logic [P_LEN-1:0] LEN_ADDR      = 4'd4;
    localparam logic [P_LEN-1:0] LEN_BMAP_ADDR = 4'd9;
    localparam logic [P_LEN-1:0] LEN_BMAP_FULL = 4'd5;

endpackage
